//--- Bender.yml
package:
  name: banked_scratch

sources:
  # design, package first
  - files:
      - verilog/scratchPkg.sv
      - verilog/axiLiteFrontEnd.sv
      - verilog/bankRouter.sv
      - verilog/sramBank.sv
      - verilog/readCollector.sv
      - verilog/bankedScratchTop.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - tb/axiLiteFrontEnd_properties.sv
      - tb/bankedScratchTb.sv

//--- compile.f
verilog/scratchPkg.sv
verilog/axiLiteFrontEnd.sv
verilog/bankRouter.sv
verilog/sramBank.sv
verilog/readCollector.sv
verilog/bankedScratchTop.sv
tb/axiLiteFrontEnd_properties.sv
tb/bankedScratchTb.sv

//--- tb/axiLiteFrontEnd_properties.sv
// --------------------
// B and R channel checks for the AXI4-Lite front end
// inactive while rst_ni is low
// --------------------

`timescale 1ns/1ps

module axiLiteFrontEnd_properties (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              bvalid_i,
  input logic              bready_i,
  input scratchPkg::resp_t bresp_i,
  input logic              rvalid_i,
  input logic              rready_i,
  input scratchPkg::data_t rdata_i,
  input scratchPkg::resp_t rresp_i,
  input logic              wordReq_i
);

  // number of failed assertions so far
  int unsigned failCount = 0;

  // a waiting write response keeps valid and code
  bHold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
      failCount++;
      $error("write response dropped or changed before bready");
    end

  // a waiting read response keeps valid, data and code
  rHold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else begin
      failCount++;
      $error("read response dropped or changed before rready");
    end

  // one transaction at a time, nothing reaches the banks while a response waits
  noReqWhileBusy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bvalid_i || rvalid_i) |-> !wordReq_i)
    else begin
      failCount++;
      $error("word request issued while a response was pending");
    end

endmodule

//--- tb/bankedScratchTb.sv
// --------------------
// testbench for the scratchpad with 4 banks of 64 words and latency 2
// table entries run in order, later reads rely on earlier writes
// ready delays and AW/W order come from a fixed seed
// --------------------

`timescale 1ns/1ps

module bankedScratchTb;

  import scratchPkg::*;

  localparam int unsigned NumBanks      = 4;
  localparam int unsigned WordsPerBank  = 64;
  localparam int unsigned Latency       = 2;
  localparam int unsigned ClkPeriod     = 8;
  localparam int unsigned ResetCycles   = 5;
  // watchdog budget per table entry
  localparam int unsigned CyclesPerTest = 40;
  // first byte address past the memory
  localparam addr_t EndAddr = addr_t'(NumBanks * WordsPerBank * StrbWidth);

  typedef enum logic {OpWrite, OpRead} op_e;

  typedef struct {
    string name;
    op_e   op;
    addr_t addr;
    data_t data;
    strb_t strb;
    data_t expData;
    resp_t expResp;
  } test_t;

  logic  clk, rstN;
  logic  awValid, awReady, wValid, wReady, bValid, bReady;
  logic  arValid, arReady, rValid, rReady;
  addr_t awAddr, arAddr;
  data_t wData, rData;
  strb_t wStrb;
  resp_t bResp, rResp;

  test_t  tests [$];
  bit     tableDone = 1'b0;
  integer seed = 32'ha089_fdb1;

  bankedScratchTop #(
    .NumBanks     (NumBanks),
    .WordsPerBank (WordsPerBank),
    .Latency      (Latency)
  ) i_bankedScratchTop (
    .clk_i     (clk),
    .rst_ni    (rstN),
    .awvalid_i (awValid),
    .awready_o (awReady),
    .awaddr_i  (awAddr),
    .wvalid_i  (wValid),
    .wready_o  (wReady),
    .wdata_i   (wData),
    .wstrb_i   (wStrb),
    .bvalid_o  (bValid),
    .bready_i  (bReady),
    .bresp_o   (bResp),
    .arvalid_i (arValid),
    .arready_o (arReady),
    .araddr_i  (arAddr),
    .rvalid_o  (rValid),
    .rready_i  (rReady),
    .rdata_o   (rData),
    .rresp_o   (rResp)
  );

  bind axiLiteFrontEnd axiLiteFrontEnd_properties i_frontEndProps (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .bvalid_i  (bvalid_o),
    .bready_i  (bready_i),
    .bresp_i   (bresp_o),
    .rvalid_i  (rvalid_o),
    .rready_i  (rready_i),
    .rdata_i   (rdata_o),
    .rresp_i   (rresp_o),
    .wordReq_i (wordReq_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk = ~clk;
    end
  end

  // expected word after a strobed write over an older word
  function automatic data_t mergeBytes(input data_t oldWord, input data_t newWord,
                                       input strb_t strb);
    data_t merged;
    merged = oldWord;
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = newWord[8*b +: 8];
      end
    end
    return merged;
  endfunction

  function automatic void addWrite(input string name, input addr_t addr, input data_t data,
                                   input strb_t strb, input resp_t expResp);
    test_t t;
    t.name    = name;
    t.op      = OpWrite;
    t.addr    = addr;
    t.data    = data;
    t.strb    = strb;
    t.expData = '0;
    t.expResp = expResp;
    tests.push_back(t);
  endfunction

  function automatic void addRead(input string name, input addr_t addr, input data_t expData,
                                  input resp_t expResp);
    test_t t;
    t.name    = name;
    t.op      = OpRead;
    t.addr    = addr;
    t.data    = '0;
    t.strb    = '0;
    t.expData = expData;
    t.expResp = expResp;
    tests.push_back(t);
  endfunction

  function automatic void buildTable();
    data_t base;
    data_t patch;
    base  = 32'hA5A5_A5A5;
    patch = 32'h0123_4567;
    // plain write and read back
    addWrite("fullWrite", 32'h0000_0000, 32'hDEAD_BEEF, 4'hF, RespOkay);
    addRead("fullRead", 32'h0000_0000, 32'hDEAD_BEEF, RespOkay);
    // bytes 0 and 2 replaced, 1 and 3 kept
    addWrite("partBase", 32'h0000_0020, base, 4'hF, RespOkay);
    addWrite("partPatch", 32'h0000_0020, patch, 4'b0101, RespOkay);
    addRead("partRead", 32'h0000_0020, mergeBytes(base, patch, 4'b0101), RespOkay);
    // words 16..19 hit banks 0..3, word 20 is bank 0 one row up
    addWrite("ilvBank0", 32'h0000_0040, 32'h1000_0001, 4'hF, RespOkay);
    addWrite("ilvBank1", 32'h0000_0044, 32'h2000_0002, 4'hF, RespOkay);
    addWrite("ilvBank2", 32'h0000_0048, 32'h3000_0003, 4'hF, RespOkay);
    addWrite("ilvBank3", 32'h0000_004C, 32'h4000_0004, 4'hF, RespOkay);
    addWrite("ilvStride", 32'h0000_0050, 32'h5000_0005, 4'hF, RespOkay);
    addRead("ilvBank0Rd", 32'h0000_0040, 32'h1000_0001, RespOkay);
    addRead("ilvBank1Rd", 32'h0000_0044, 32'h2000_0002, RespOkay);
    addRead("ilvBank2Rd", 32'h0000_0048, 32'h3000_0003, RespOkay);
    addRead("ilvBank3Rd", 32'h0000_004C, 32'h4000_0004, RespOkay);
    addRead("ilvStrideRd", 32'h0000_0050, 32'h5000_0005, RespOkay);
    // byte offset bits do not matter
    addRead("byteOffset", 32'h0000_0047, 32'h2000_0002, RespOkay);
    // top word still in range
    addWrite("lastWord", EndAddr - 4, 32'h7E57_0FF5, 4'hF, RespOkay);
    addRead("lastWordRd", EndAddr - 4, 32'h7E57_0FF5, RespOkay);
    // word 256 would alias word 0 if it got through
    addWrite("oorWrite", EndAddr, 32'hBAD0_BAD0, 4'hF, RespSlvErr);
    addRead("oorRead", EndAddr, '0, RespSlvErr);
    addRead("oorHigh", 32'hFFFF_FFFC, '0, RespSlvErr);
    addRead("word0After", 32'h0000_0000, 32'hDEAD_BEEF, RespOkay);
  endfunction

  task automatic compareData(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display("sim failed");
      $fatal(1, "data check stopped the run");
    end
  endtask

  task automatic compareResp(input string name, input resp_t expected, input resp_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected resp %02b, actual resp %02b", name, expected, actual);
      $display("sim failed");
      $fatal(1, "response check stopped the run");
    end
  endtask

  // all tasks start and end right after a rising edge
  task automatic sendAw(input addr_t addr, input int delay);
    logic accepted;
    repeat (delay) @(posedge clk);
    awValid <= 1'b1;
    awAddr  <= addr;
    do begin
      @(negedge clk);
      accepted = awReady;
      @(posedge clk);
    end while (!accepted);
    awValid <= 1'b0;
  endtask

  task automatic sendW(input data_t data, input strb_t strb, input int delay);
    logic accepted;
    repeat (delay) @(posedge clk);
    wValid <= 1'b1;
    wData  <= data;
    wStrb  <= strb;
    do begin
      @(negedge clk);
      accepted = wReady;
      @(posedge clk);
    end while (!accepted);
    wValid <= 1'b0;
  endtask

  task automatic driveWrite(input addr_t addr, input data_t data, input strb_t strb,
                            output resp_t resp);
    int order;
    int delay;
    // 0 same cycle, 1 AW first, 2 W first
    order = $unsigned($random(seed)) % 3;
    delay = $unsigned($random(seed)) % 4;
    fork
      sendAw(addr, (order == 2) ? 1 : 0);
      sendW(data, strb, (order == 1) ? 1 : 0);
    join
    @(negedge clk);
    while (!bValid) begin
      @(negedge clk);
    end
    // hold bready low a few cycles to exercise back-pressure
    repeat (delay) @(posedge clk);
    @(posedge clk);
    bReady <= 1'b1;
    @(negedge clk);
    resp = bResp;
    @(posedge clk);
    bReady <= 1'b0;
  endtask

  task automatic driveRead(input addr_t addr, output data_t data, output resp_t resp);
    logic accepted;
    int   delay;
    delay = $unsigned($random(seed)) % 4;
    arValid <= 1'b1;
    arAddr  <= addr;
    do begin
      @(negedge clk);
      accepted = arReady;
      @(posedge clk);
    end while (!accepted);
    arValid <= 1'b0;
    @(negedge clk);
    while (!rValid) begin
      @(negedge clk);
    end
    repeat (delay) @(posedge clk);
    @(posedge clk);
    rReady <= 1'b1;
    @(negedge clk);
    data = rData;
    resp = rResp;
    @(posedge clk);
    rReady <= 1'b0;
  endtask

  initial begin : mainFlow
    resp_t resp;
    data_t data;
    rstN    = 1'b0;
    awValid = 1'b0;
    awAddr  = '0;
    wValid  = 1'b0;
    wData   = '0;
    wStrb   = '0;
    bReady  = 1'b0;
    arValid = 1'b0;
    arAddr  = '0;
    rReady  = 1'b0;
    buildTable();
    tableDone = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;
    foreach (tests[i]) begin
      if (tests[i].op == OpWrite) begin
        driveWrite(tests[i].addr, tests[i].data, tests[i].strb, resp);
        compareResp(tests[i].name, tests[i].expResp, resp);
      end else begin
        driveRead(tests[i].addr, data, resp);
        compareResp(tests[i].name, tests[i].expResp, resp);
        // read data is undefined on an error response
        if (tests[i].expResp == RespOkay) begin
          compareData(tests[i].name, tests[i].expData, data);
        end
      end
    end
    if (i_bankedScratchTop.i_axiLiteFrontEnd.i_frontEndProps.failCount == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("ERROR: %0d channel assertion failures during the run",
               i_bankedScratchTop.i_axiLiteFrontEnd.i_frontEndProps.failCount);
      $display("sim failed");
      $fatal(1, "assertions failed");
    end
  end

  // first failure of a bound channel check
  initial begin : assertMonitor
    wait (i_bankedScratchTop.i_axiLiteFrontEnd.i_frontEndProps.failCount != 0);
    $display("ERROR: a channel assertion on the B or R channel failed");
    $display("sim failed");
    $fatal(1, "assertion failure stopped the run");
  end

  initial begin : watchdog
    wait (tableDone);
    #(tests.size() * CyclesPerTest * ClkPeriod);
    $display("ERROR: timeout, the DUT did not finish the table in time");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- verilog/axiLiteFrontEnd.sv
// --------------------
// AXI4-Lite slave, one transaction in progress at a time
// writes win over reads when both wait
// out-of-range accesses get SLVERR and never reach a bank
// --------------------

`timescale 1ns/1ps

module axiLiteFrontEnd #(
  parameter int unsigned NumBanks     = 4,
  parameter int unsigned WordsPerBank = 64
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // AW channel
  input  logic                awvalid_i,
  output logic                awready_o,
  input  scratchPkg::addr_t   awaddr_i,
  // W channel
  input  logic                wvalid_i,
  output logic                wready_o,
  input  scratchPkg::data_t   wdata_i,
  input  scratchPkg::strb_t   wstrb_i,
  // B channel
  output logic                bvalid_o,
  input  logic                bready_i,
  output scratchPkg::resp_t   bresp_o,
  // AR channel
  input  logic                arvalid_i,
  output logic                arready_o,
  input  scratchPkg::addr_t   araddr_i,
  // R channel
  output logic                rvalid_o,
  input  logic                rready_i,
  output scratchPkg::data_t   rdata_o,
  output scratchPkg::resp_t   rresp_o,
  // word request towards the router
  output logic                wordReq_o,
  output logic                wordWe_o,
  output scratchPkg::addr_t   wordAddr_o,
  output scratchPkg::data_t   wordData_o,
  output scratchPkg::strb_t   wordStrb_o,
  // read return from the collector
  input  logic                rspValid_i,
  input  scratchPkg::data_t   rspData_i
);

  import scratchPkg::*;

  // total number of words over all banks
  localparam addr_t MemWords = addr_t'(NumBanks * WordsPerBank);

  // StInit keeps all readies low for one cycle after reset
  typedef enum logic [2:0] {
    StInit,
    StIdle,
    StRdReq,
    StRdWait,
    StWrResp,
    StRdResp
  } state_e;

  state_e stateQ, stateD;

  // AW and W arrive independently, flags mark which one is held
  logic  awHeldQ, wHeldQ;
  // AW and AR never handshake together so one address register serves both
  addr_t reqAddrQ;
  data_t wDataQ;
  strb_t wStrbQ;

  // registered responses, steady while waiting for ready
  resp_t brespQ, rrespQ;
  data_t rdataQ;

  logic  awHs, wHs, arHs;
  logic  wrFire;
  logic  inRange;
  addr_t wordIdx;

  // AW and W accepted only while idle and not yet held
  assign awready_o = (stateQ == StIdle) && !awHeldQ;
  assign wready_o  = (stateQ == StIdle) && !wHeldQ;
  // a read is taken only when no part of a write is pending
  assign arready_o = (stateQ == StIdle) && !awHeldQ && !wHeldQ && !awvalid_i && !wvalid_i;

  assign awHs = awvalid_i && awready_o;
  assign wHs  = wvalid_i && wready_o;
  assign arHs = arvalid_i && arready_o;

  // byte offset bits dropped
  assign wordIdx = reqAddrQ >> $clog2(StrbWidth);
  assign inRange = wordIdx < MemWords;

  // write executes in the first cycle with both halves held
  assign wrFire = (stateQ == StIdle) && awHeldQ && wHeldQ;

  // single-cycle request, suppressed for out-of-range addresses
  assign wordReq_o  = (wrFire || (stateQ == StRdReq)) && inRange;
  assign wordWe_o   = (stateQ == StIdle);
  assign wordAddr_o = wordIdx;
  assign wordData_o = wDataQ;
  assign wordStrb_o = wStrbQ;

  assign bvalid_o = (stateQ == StWrResp);
  assign bresp_o  = brespQ;
  assign rvalid_o = (stateQ == StRdResp);
  assign rresp_o  = rrespQ;
  assign rdata_o  = rdataQ;

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      StInit: begin
        stateD = StIdle;
      end
      StIdle: begin
        if (wrFire) begin
          stateD = StWrResp;
        end else if (arHs) begin
          stateD = StRdReq;
        end
      end
      // illegal reads answer right away
      StRdReq: begin
        stateD = inRange ? StRdWait : StRdResp;
      end
      StRdWait: begin
        if (rspValid_i) begin
          stateD = StRdResp;
        end
      end
      StWrResp: begin
        if (bready_i) begin
          stateD = StIdle;
        end
      end
      StRdResp: begin
        if (rready_i) begin
          stateD = StIdle;
        end
      end
      default: begin
        stateD = StIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stateQ  <= StInit;
      awHeldQ <= 1'b0;
      wHeldQ  <= 1'b0;
    end else begin
      stateQ <= stateD;
      // held flags cleared once the write has gone out
      if (wrFire) begin
        awHeldQ <= 1'b0;
        wHeldQ  <= 1'b0;
      end else begin
        if (awHs) begin
          awHeldQ <= 1'b1;
        end
        if (wHs) begin
          wHeldQ <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (awHs) begin
      reqAddrQ <= awaddr_i;
    end else if (arHs) begin
      reqAddrQ <= araddr_i;
    end
    if (wHs) begin
      wDataQ <= wdata_i;
      wStrbQ <= wstrb_i;
    end
    if (wrFire) begin
      brespQ <= inRange ? RespOkay : RespSlvErr;
    end
    // error read returns zero data
    if ((stateQ == StRdReq) && !inRange) begin
      rrespQ <= RespSlvErr;
      rdataQ <= '0;
    end else if ((stateQ == StRdWait) && rspValid_i) begin
      rrespQ <= RespOkay;
      rdataQ <= rspData_i;
    end
  end

endmodule

//--- verilog/bankRouter.sv
// --------------------
// combinational address decode, low-order interleaving
// NumBanks must be a power of two
// --------------------

`timescale 1ns/1ps

module bankRouter #(
  parameter int unsigned NumBanks     = 4,
  parameter int unsigned WordsPerBank = 64,
  localparam int unsigned BankIdxWidth = (NumBanks > 1) ? $clog2(NumBanks) : 1,
  localparam int unsigned RowWidth     = (WordsPerBank > 1) ? $clog2(WordsPerBank) : 1
) (
  // word request from the front end
  input  logic                    wordReq_i,
  input  logic                    wordWe_i,
  input  scratchPkg::addr_t       wordAddr_i,
  input  scratchPkg::data_t       wordData_i,
  input  scratchPkg::strb_t       wordStrb_i,
  // one request line per bank, the rest is shared
  output logic [NumBanks-1:0]     bankReq_o,
  output logic                    bankWe_o,
  output logic [RowWidth-1:0]     bankRow_o,
  output scratchPkg::data_t       bankData_o,
  output scratchPkg::strb_t       bankStrb_o,
  // read tracking for the collector
  output logic                    rdIssue_o,
  output logic [BankIdxWidth-1:0] rdBank_o
);

  logic [BankIdxWidth-1:0] bankIdx;

  // modulo and divide by a power of two reduce to bit slices
  assign bankIdx   = BankIdxWidth'(wordAddr_i % NumBanks);
  assign bankRow_o = RowWidth'(wordAddr_i / NumBanks);

  // only the addressed bank sees the request
  always_comb begin
    bankReq_o          = '0;
    bankReq_o[bankIdx] = wordReq_i;
  end

  // write payload broadcast, banks without req ignore it
  assign bankWe_o   = wordWe_i;
  assign bankData_o = wordData_i;
  assign bankStrb_o = wordStrb_i;

  // reads are tagged with their bank so the right data comes back
  assign rdIssue_o = wordReq_i && !wordWe_i;
  assign rdBank_o  = bankIdx;

endmodule

//--- verilog/bankedScratchTop.sv
// --------------------
// banked scratchpad behind an AXI4-Lite slave
// NumBanks and WordsPerBank powers of two, Latency >= 1
// --------------------

`timescale 1ns/1ps

module bankedScratchTop #(
  parameter int unsigned NumBanks     = 4,
  parameter int unsigned WordsPerBank = 64,
  parameter int unsigned Latency      = 1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              awvalid_i,
  output logic              awready_o,
  input  scratchPkg::addr_t awaddr_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  input  scratchPkg::data_t wdata_i,
  input  scratchPkg::strb_t wstrb_i,
  output logic              bvalid_o,
  input  logic              bready_i,
  output scratchPkg::resp_t bresp_o,
  input  logic              arvalid_i,
  output logic              arready_o,
  input  scratchPkg::addr_t araddr_i,
  output logic              rvalid_o,
  input  logic              rready_i,
  output scratchPkg::data_t rdata_o,
  output scratchPkg::resp_t rresp_o
);

  import scratchPkg::*;

  localparam int unsigned BankIdxWidth = (NumBanks > 1) ? $clog2(NumBanks) : 1;
  localparam int unsigned RowWidth     = (WordsPerBank > 1) ? $clog2(WordsPerBank) : 1;

  // front end to router
  logic  wordReq, wordWe;
  addr_t wordAddr;
  data_t wordData;
  strb_t wordStrb;

  // router to banks
  logic [NumBanks-1:0] bankReq;
  logic                bankWe;
  logic [RowWidth-1:0] bankRow;
  data_t               bankData;
  strb_t               bankStrb;
  data_t               bankRdata [NumBanks];

  // read tracking and return path
  logic                    rdIssue;
  logic [BankIdxWidth-1:0] rdBank;
  logic                    rspValid;
  data_t                   rspData;

  axiLiteFrontEnd #(
    .NumBanks     (NumBanks),
    .WordsPerBank (WordsPerBank)
  ) i_axiLiteFrontEnd (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .awvalid_i  (awvalid_i),
    .awready_o  (awready_o),
    .awaddr_i   (awaddr_i),
    .wvalid_i   (wvalid_i),
    .wready_o   (wready_o),
    .wdata_i    (wdata_i),
    .wstrb_i    (wstrb_i),
    .bvalid_o   (bvalid_o),
    .bready_i   (bready_i),
    .bresp_o    (bresp_o),
    .arvalid_i  (arvalid_i),
    .arready_o  (arready_o),
    .araddr_i   (araddr_i),
    .rvalid_o   (rvalid_o),
    .rready_i   (rready_i),
    .rdata_o    (rdata_o),
    .rresp_o    (rresp_o),
    .wordReq_o  (wordReq),
    .wordWe_o   (wordWe),
    .wordAddr_o (wordAddr),
    .wordData_o (wordData),
    .wordStrb_o (wordStrb),
    .rspValid_i (rspValid),
    .rspData_i  (rspData)
  );

  bankRouter #(
    .NumBanks     (NumBanks),
    .WordsPerBank (WordsPerBank)
  ) i_bankRouter (
    .wordReq_i  (wordReq),
    .wordWe_i   (wordWe),
    .wordAddr_i (wordAddr),
    .wordData_i (wordData),
    .wordStrb_i (wordStrb),
    .bankReq_o  (bankReq),
    .bankWe_o   (bankWe),
    .bankRow_o  (bankRow),
    .bankData_o (bankData),
    .bankStrb_o (bankStrb),
    .rdIssue_o  (rdIssue),
    .rdBank_o   (rdBank)
  );

  // identical banks, each with its own request line
  for (genvar i = 0; i < NumBanks; i++) begin : gen_bank
    sramBank #(
      .WordsPerBank (WordsPerBank),
      .Latency      (Latency)
    ) i_sramBank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (bankReq[i]),
      .we_i    (bankWe),
      .row_i   (bankRow),
      .wdata_i (bankData),
      .strb_i  (bankStrb),
      .rdata_o (bankRdata[i])
    );
  end

  readCollector #(
    .NumBanks (NumBanks),
    .Latency  (Latency)
  ) i_readCollector (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rdIssue_i   (rdIssue),
    .rdBank_i    (rdBank),
    .bankRdata_i (bankRdata),
    .rspValid_o  (rspValid),
    .rspData_o   (rspData)
  );

endmodule

//--- verilog/readCollector.sv
// --------------------
// matches bank read latency, Latency >= 1
// several reads may be in flight
// --------------------

`timescale 1ns/1ps

module readCollector #(
  parameter int unsigned NumBanks = 4,
  parameter int unsigned Latency  = 1,
  localparam int unsigned BankIdxWidth = (NumBanks > 1) ? $clog2(NumBanks) : 1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    rdIssue_i,
  input  logic [BankIdxWidth-1:0] rdBank_i,
  input  scratchPkg::data_t       bankRdata_i [NumBanks],
  output logic                    rspValid_o,
  output scratchPkg::data_t       rspData_o
);

  // entry 0 is loaded on the issue edge, Latency-1 is the exit
  logic                    issueQ [Latency];
  logic [BankIdxWidth-1:0] bankQ  [Latency];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned j = 0; j < Latency; j++) begin
        issueQ[j] <= 1'b0;
        bankQ[j]  <= '0;
      end
    end else begin
      issueQ[0] <= rdIssue_i;
      bankQ[0]  <= rdBank_i;
      for (int unsigned j = 1; j < Latency; j++) begin
        issueQ[j] <= issueQ[j-1];
        bankQ[j]  <= bankQ[j-1];
      end
    end
  end

  // exit lines up with the cycle the bank presents its data
  assign rspValid_o = issueQ[Latency-1];
  assign rspData_o  = bankRdata_i[bankQ[Latency-1]];

endmodule

//--- verilog/scratchPkg.sv
// --------------------
// shared widths and types of the banked scratchpad
// data word fixed at 32 bits with byte strobes
// response codes follow the AXI4-Lite encoding
// --------------------

package scratchPkg;

  // AXI4-Lite byte address width
  localparam int unsigned AxiAddrWidth = 32;

  // width of one data word
  localparam int unsigned DataWidth = 32;

  // one strobe bit per byte of a word
  localparam int unsigned StrbWidth = DataWidth / 8;

  // byte address as seen on the AW and AR channels
  typedef logic [AxiAddrWidth-1:0] addr_t;

  // one data word on W, R and the bank ports
  typedef logic [DataWidth-1:0] data_t;

  // byte write enables
  typedef logic [StrbWidth-1:0] strb_t;

  // AXI response code on B and R
  typedef logic [1:0] resp_t;

  // access completed
  localparam resp_t RespOkay = 2'b00;

  // access rejected, used for out-of-range addresses
  localparam resp_t RespSlvErr = 2'b10;

endpackage

//--- verilog/sramBank.sv
// --------------------
// single-port SRAM bank with byte strobes
// read data appears Latency cycles after a read request, Latency >= 1
// output holds the last read row while idle
// --------------------

`timescale 1ns/1ps

module sramBank #(
  parameter int unsigned WordsPerBank = 64,
  parameter int unsigned Latency      = 1,
  localparam int unsigned RowWidth    = (WordsPerBank > 1) ? $clog2(WordsPerBank) : 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  logic                we_i,
  input  logic [RowWidth-1:0] row_i,
  input  scratchPkg::data_t   wdata_i,
  input  scratchPkg::strb_t   strb_i,
  output scratchPkg::data_t   rdata_o
);

  import scratchPkg::*;

  // bits covered by one strobe
  localparam int unsigned ByteBits = DataWidth / StrbWidth;

  // storage
  data_t mem [WordsPerBank];

  // row of the most recent read
  logic [RowWidth-1:0] rRowQ;

  // read delay line, entry 0 drives the output
  data_t rdataQ [Latency];
  data_t readWord;

  // new row on a read, otherwise keep presenting the old one
  assign readWord = (req_i && !we_i) ? mem[row_i] : mem[rRowQ];
  assign rdata_o  = rdataQ[0];

  // byte-enabled write on the request edge
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < StrbWidth; b++) begin
        if (strb_i[b]) begin
          mem[row_i][b*ByteBits +: ByteBits] <= wdata_i[b*ByteBits +: ByteBits];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rRowQ <= '0;
      for (int unsigned j = 0; j < Latency; j++) begin
        rdataQ[j] <= '0;
      end
    end else begin
      // array is sampled before any write of this edge lands
      rdataQ[Latency-1] <= readWord;
      for (int unsigned j = 0; j + 1 < Latency; j++) begin
        rdataQ[j] <= rdataQ[j+1];
      end
      if (req_i && !we_i) begin
        rRowQ <= row_i;
      end
    end
  end

endmodule
